// ==== hdl/udp_echo_pkg.sv ====
/*
 * Shared field types and default constants for the UDP echo application
 */
`default_nettype none

package udp_echo_pkg;

    // Payload byte and header field types
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;

    // Port answered by the echo logic
    parameter udp_port_t DEFAULT_ECHO_PORT = 16'd1234;

    // 192.168.1.128
    parameter ip_addr_t DEFAULT_LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128};

    // Payload FIFO depth as an address width, 4096 bytes
    parameter int DEFAULT_FIFO_ADDR_WIDTH = 12;

endpackage

`default_nettype wire

// ==== hdl/byte_stream_if.sv ====
/*
 * Byte payload stream with valid/ready handshake, last and user flags
 */
`default_nettype none

interface byte_stream_if;
    import udp_echo_pkg::*;

    byte_t data;
    logic  valid;
    logic  ready;
    logic  last;
    logic  user;

    modport source (output data, valid, last, user, input ready);
    modport sink (input data, valid, last, user, output ready);

    // Passive view, used to observe the output stream
    modport monitor (input data, valid, ready, last, user);

endinterface

`default_nettype wire

// ==== hdl/udp_hdr_if.sv ====
/*
 * UDP header transfer with valid/ready handshake
 */
`default_nettype none

interface udp_hdr_if;
    import udp_echo_pkg::*;

    logic      valid;
    logic      ready;
    ip_addr_t  src_ip;
    ip_addr_t  dst_ip;
    udp_port_t src_port;
    udp_port_t dst_port;
    udp_len_t  length;

    modport source (
        output valid, src_ip, dst_ip, src_port, dst_port, length,
        input  ready
    );

    modport sink (
        input  valid, src_ip, dst_ip, src_port, dst_port, length,
        output ready
    );

endinterface

`default_nettype wire

// ==== hdl/udp_port_filter.sv ====
/*
 * Echo port filter: matches each header against the echo port,
 * forwards matching frames and drains all others
 */
`default_nettype none

module udp_port_filter #(
    parameter udp_echo_pkg::udp_port_t ECHO_PORT = udp_echo_pkg::DEFAULT_ECHO_PORT
) (
    input  wire                          clk_125mhz,
    input  wire                          rst_125mhz,

    input  wire                          in_hdr_valid,
    input  wire udp_echo_pkg::ip_addr_t  in_src_ip,
    input  wire udp_echo_pkg::ip_addr_t  in_dst_ip,
    input  wire udp_echo_pkg::udp_port_t in_src_port,
    input  wire udp_echo_pkg::udp_port_t in_dst_port,
    input  wire udp_echo_pkg::udp_len_t  in_length,
    output logic                         in_hdr_ready,

    input  wire udp_echo_pkg::byte_t     in_payload_data,
    input  wire                          in_payload_valid,
    input  wire                          in_payload_last,
    input  wire                          in_payload_user,
    output logic                         in_payload_ready,

    udp_hdr_if.source                    hdr_out,
    byte_stream_if.source                payload_out
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_PASS = 2'd1;
    localparam logic [1:0] ST_DROP = 2'd2;

    logic [1:0] state;
    logic       hdr_match;
    logic       hdr_accept;
    logic       last_accept;

    assign hdr_match = (in_dst_port == ECHO_PORT);

    // Headers are taken only between frames
    assign in_hdr_ready = (state == ST_IDLE) && (hdr_match ? hdr_out.ready : 1'b1);
    assign hdr_accept   = in_hdr_valid && in_hdr_ready;

    assign hdr_out.valid    = (state == ST_IDLE) && in_hdr_valid && hdr_match;
    assign hdr_out.src_ip   = in_src_ip;
    assign hdr_out.dst_ip   = in_dst_ip;
    assign hdr_out.src_port = in_src_port;
    assign hdr_out.dst_port = in_dst_port;
    assign hdr_out.length   = in_length;

    // Payload goes to the FIFO in pass, is swallowed in drop
    assign in_payload_ready = (state == ST_PASS) ? payload_out.ready : (state == ST_DROP);
    assign last_accept      = in_payload_valid && in_payload_ready && in_payload_last;

    assign payload_out.valid = in_payload_valid && (state == ST_PASS);
    assign payload_out.data  = in_payload_data;
    assign payload_out.last  = in_payload_last;
    assign payload_out.user  = in_payload_user;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (hdr_accept) begin
                        state <= hdr_match ? ST_PASS : ST_DROP;
                    end
                end
                ST_PASS, ST_DROP: begin
                    if (last_accept) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/udp_reply_header.sv ====
/*
 * Reply header register: swaps ports and addresses of a matched
 * request and holds the result until the output takes it
 */
`default_nettype none

module udp_reply_header #(
    parameter udp_echo_pkg::ip_addr_t LOCAL_IP = udp_echo_pkg::DEFAULT_LOCAL_IP
) (
    input  wire                          clk_125mhz,
    input  wire                          rst_125mhz,

    udp_hdr_if.sink                      hdr_in,

    output logic                         out_hdr_valid,
    output udp_echo_pkg::ip_addr_t       out_src_ip,
    output udp_echo_pkg::ip_addr_t       out_dst_ip,
    output udp_echo_pkg::udp_port_t      out_src_port,
    output udp_echo_pkg::udp_port_t      out_dst_port,
    output udp_echo_pkg::udp_len_t       out_length,
    input  wire                          out_hdr_ready
);
    import udp_echo_pkg::*;

    logic      reply_valid;
    ip_addr_t  reply_dst_ip;
    udp_port_t reply_src_port;
    udp_port_t reply_dst_port;
    udp_len_t  reply_length;

    // Free, or drained on this edge
    assign hdr_in.ready = !reply_valid || out_hdr_ready;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            reply_valid <= 1'b0;
        end else if (hdr_in.valid && hdr_in.ready) begin
            reply_valid <= 1'b1;
        end else if (out_hdr_ready) begin
            reply_valid <= 1'b0;
        end
    end

    // Reply goes back where the request came from
    always_ff @(posedge clk_125mhz) begin
        if (hdr_in.valid && hdr_in.ready) begin
            reply_dst_ip   <= hdr_in.src_ip;
            reply_src_port <= hdr_in.dst_port;
            reply_dst_port <= hdr_in.src_port;
            reply_length   <= hdr_in.length;
        end
    end

    assign out_hdr_valid = reply_valid;
    assign out_src_ip    = LOCAL_IP;
    assign out_dst_ip    = reply_dst_ip;
    assign out_src_port  = reply_src_port;
    assign out_dst_port  = reply_dst_port;
    assign out_length    = reply_length;

endmodule

`default_nettype wire

// ==== hdl/payload_fifo.sv ====
/*
 * Synchronous byte FIFO with last and user flags and a registered head
 */
`default_nettype none

module payload_fifo #(
    parameter int FIFO_ADDR_WIDTH = udp_echo_pkg::DEFAULT_FIFO_ADDR_WIDTH
) (
    input  wire           clk_125mhz,
    input  wire           rst_125mhz,

    byte_stream_if.sink   wr,
    byte_stream_if.source rd
);
    import udp_echo_pkg::*;

    localparam int DEPTH   = 2 ** FIFO_ADDR_WIDTH;
    localparam int ENTRY_W = $bits(byte_t) + 2;

    // Entry layout is {last, user, data}
    logic [ENTRY_W-1:0] mem [0:DEPTH-1];

    logic [FIFO_ADDR_WIDTH:0] wr_ptr;
    logic [FIFO_ADDR_WIDTH:0] rd_ptr;
    logic [FIFO_ADDR_WIDTH:0] wr_ptr_next;
    logic [FIFO_ADDR_WIDTH:0] rd_ptr_next;
    logic                     full;
    logic                     wr_en;
    logic                     rd_en;

    logic                     head_valid;
    byte_t                    head_data;
    logic                     head_last;
    logic                     head_user;

    // Same address, opposite wrap bit
    assign full = (wr_ptr[FIFO_ADDR_WIDTH] != rd_ptr[FIFO_ADDR_WIDTH]) &&
                  (wr_ptr[FIFO_ADDR_WIDTH-1:0] == rd_ptr[FIFO_ADDR_WIDTH-1:0]);

    assign wr.ready = !full;
    assign wr_en    = wr.valid && !full;
    assign rd_en    = head_valid && rd.ready;

    assign wr_ptr_next = wr_ptr + {{FIFO_ADDR_WIDTH{1'b0}}, wr_en};
    assign rd_ptr_next = rd_ptr + {{FIFO_ADDR_WIDTH{1'b0}}, rd_en};

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            head_valid <= 1'b0;
        end else begin
            wr_ptr     <= wr_ptr_next;
            rd_ptr     <= rd_ptr_next;
            head_valid <= (rd_ptr_next != wr_ptr_next);
        end
    end

    // Head register always mirrors the oldest stored entry
    always_ff @(posedge clk_125mhz) begin
        if (wr_en) begin
            mem[wr_ptr[FIFO_ADDR_WIDTH-1:0]] <= {wr.last, wr.user, wr.data};
        end
        if (rd_ptr_next == wr_ptr) begin
            // Entry being written now becomes the head, skip the RAM
            {head_last, head_user, head_data} <= {wr.last, wr.user, wr.data};
        end else begin
            {head_last, head_user, head_data} <= mem[rd_ptr_next[FIFO_ADDR_WIDTH-1:0]];
        end
    end

    assign rd.valid = head_valid;
    assign rd.data  = head_data;
    assign rd.last  = head_last;
    assign rd.user  = head_user;

endmodule

`default_nettype wire

// ==== hdl/led_capture.sv ====
/*
 * LED register holding the first byte of each outgoing frame
 */
`default_nettype none

module led_capture (
    input  wire                   clk_125mhz,
    input  wire                   rst_125mhz,

    byte_stream_if.monitor        mon,

    output udp_echo_pkg::byte_t   led
);

    // Set once the current frame's first byte has been seen
    logic frame_started;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            led           <= '0;
            frame_started <= 1'b0;
        end else begin
            if (mon.valid && !frame_started) begin
                led           <= mon.data;
                frame_started <= 1'b1;
            end
            // Later assignment wins for one-byte frames
            if (mon.valid && mon.ready && mon.last) begin
                frame_started <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/udp_echo_top.sv ====
/*
 * UDP echo application top level: port filter, reply header,
 * payload FIFO and LED capture
 */
`default_nettype none

module udp_echo_top #(
    parameter udp_echo_pkg::udp_port_t ECHO_PORT       = udp_echo_pkg::DEFAULT_ECHO_PORT,
    parameter udp_echo_pkg::ip_addr_t  LOCAL_IP        = udp_echo_pkg::DEFAULT_LOCAL_IP,
    parameter int                      FIFO_ADDR_WIDTH = udp_echo_pkg::DEFAULT_FIFO_ADDR_WIDTH
) (
    input  wire                          clk_125mhz,
    input  wire                          rst_125mhz,

    // Request header and payload from the UDP stack
    input  wire                          in_hdr_valid,
    input  wire udp_echo_pkg::ip_addr_t  in_src_ip,
    input  wire udp_echo_pkg::ip_addr_t  in_dst_ip,
    input  wire udp_echo_pkg::udp_port_t in_src_port,
    input  wire udp_echo_pkg::udp_port_t in_dst_port,
    input  wire udp_echo_pkg::udp_len_t  in_length,
    output logic                         in_hdr_ready,
    input  wire udp_echo_pkg::byte_t     in_payload_data,
    input  wire                          in_payload_valid,
    input  wire                          in_payload_last,
    input  wire                          in_payload_user,
    output logic                         in_payload_ready,

    // Reply header and payload to the UDP stack
    output logic                         out_hdr_valid,
    output udp_echo_pkg::ip_addr_t       out_src_ip,
    output udp_echo_pkg::ip_addr_t       out_dst_ip,
    output udp_echo_pkg::udp_port_t      out_src_port,
    output udp_echo_pkg::udp_port_t      out_dst_port,
    output udp_echo_pkg::udp_len_t       out_length,
    input  wire                          out_hdr_ready,
    output udp_echo_pkg::byte_t          out_payload_data,
    output logic                         out_payload_valid,
    output logic                         out_payload_last,
    output logic                         out_payload_user,
    input  wire                          out_payload_ready,

    output udp_echo_pkg::byte_t          led
);

    udp_hdr_if     filter_to_reply ();
    byte_stream_if filter_to_fifo ();
    byte_stream_if fifo_out ();

    udp_port_filter #(
        .ECHO_PORT (ECHO_PORT)
    ) i_udp_port_filter (
        .clk_125mhz       (clk_125mhz),
        .rst_125mhz       (rst_125mhz),
        .in_hdr_valid     (in_hdr_valid),
        .in_src_ip        (in_src_ip),
        .in_dst_ip        (in_dst_ip),
        .in_src_port      (in_src_port),
        .in_dst_port      (in_dst_port),
        .in_length        (in_length),
        .in_hdr_ready     (in_hdr_ready),
        .in_payload_data  (in_payload_data),
        .in_payload_valid (in_payload_valid),
        .in_payload_last  (in_payload_last),
        .in_payload_user  (in_payload_user),
        .in_payload_ready (in_payload_ready),
        .hdr_out          (filter_to_reply.source),
        .payload_out      (filter_to_fifo.source)
    );

    udp_reply_header #(
        .LOCAL_IP (LOCAL_IP)
    ) i_udp_reply_header (
        .clk_125mhz    (clk_125mhz),
        .rst_125mhz    (rst_125mhz),
        .hdr_in        (filter_to_reply.sink),
        .out_hdr_valid (out_hdr_valid),
        .out_src_ip    (out_src_ip),
        .out_dst_ip    (out_dst_ip),
        .out_src_port  (out_src_port),
        .out_dst_port  (out_dst_port),
        .out_length    (out_length),
        .out_hdr_ready (out_hdr_ready)
    );

    payload_fifo #(
        .FIFO_ADDR_WIDTH (FIFO_ADDR_WIDTH)
    ) i_payload_fifo (
        .clk_125mhz (clk_125mhz),
        .rst_125mhz (rst_125mhz),
        .wr         (filter_to_fifo.sink),
        .rd         (fifo_out.source)
    );

    led_capture i_led_capture (
        .clk_125mhz (clk_125mhz),
        .rst_125mhz (rst_125mhz),
        .mon        (fifo_out.monitor),
        .led        (led)
    );

    // FIFO output drives the reply payload ports
    assign out_payload_data  = fifo_out.data;
    assign out_payload_valid = fifo_out.valid;
    assign out_payload_last  = fifo_out.last;
    assign out_payload_user  = fifo_out.user;
    assign fifo_out.ready    = out_payload_ready;

endmodule

`default_nettype wire

// ==== bench/tb_udp_echo.sv ====
/*
 * Testbench for the UDP echo top level: frame generator, reference
 * model for the reply header, output comparator and cycle timeout
 */
`default_nettype none

module tb_udp_echo;
    timeunit 1ns;
    timeprecision 1ps;

    import udp_echo_pkg::*;

    localparam int NUM_FRAMES  = 206;
    localparam int CYCLE_LIMIT = 40 * NUM_FRAMES + 1000;

    typedef struct packed {
        ip_addr_t  src_ip;
        ip_addr_t  dst_ip;
        udp_port_t src_port;
        udp_port_t dst_port;
        udp_len_t  length;
    } hdr_t;

    typedef struct packed {
        logic  last;
        logic  user;
        byte_t data;
    } beat_t;

    logic      clk_125mhz;
    logic      rst_125mhz;
    logic      in_hdr_valid;
    ip_addr_t  in_src_ip;
    ip_addr_t  in_dst_ip;
    udp_port_t in_src_port;
    udp_port_t in_dst_port;
    udp_len_t  in_length;
    logic      in_hdr_ready;
    byte_t     in_payload_data;
    logic      in_payload_valid;
    logic      in_payload_last;
    logic      in_payload_user;
    logic      in_payload_ready;
    logic      out_hdr_valid;
    ip_addr_t  out_src_ip;
    ip_addr_t  out_dst_ip;
    udp_port_t out_src_port;
    udp_port_t out_dst_port;
    udp_len_t  out_length;
    logic      out_hdr_ready;
    byte_t     out_payload_data;
    logic      out_payload_valid;
    logic      out_payload_last;
    logic      out_payload_user;
    logic      out_payload_ready;
    byte_t     led;

    hdr_t  exp_hdr_q[$];
    beat_t exp_pay_q[$];
    byte_t exp_led;
    logic  stall_outputs;
    int    errors;
    int    tests_run;
    int    cycles;

    udp_echo_top i_udp_echo_top (
        .clk_125mhz        (clk_125mhz),
        .rst_125mhz        (rst_125mhz),
        .in_hdr_valid      (in_hdr_valid),
        .in_src_ip         (in_src_ip),
        .in_dst_ip         (in_dst_ip),
        .in_src_port       (in_src_port),
        .in_dst_port       (in_dst_port),
        .in_length         (in_length),
        .in_hdr_ready      (in_hdr_ready),
        .in_payload_data   (in_payload_data),
        .in_payload_valid  (in_payload_valid),
        .in_payload_last   (in_payload_last),
        .in_payload_user   (in_payload_user),
        .in_payload_ready  (in_payload_ready),
        .out_hdr_valid     (out_hdr_valid),
        .out_src_ip        (out_src_ip),
        .out_dst_ip        (out_dst_ip),
        .out_src_port      (out_src_port),
        .out_dst_port      (out_dst_port),
        .out_length        (out_length),
        .out_hdr_ready     (out_hdr_ready),
        .out_payload_data  (out_payload_data),
        .out_payload_valid (out_payload_valid),
        .out_payload_last  (out_payload_last),
        .out_payload_user  (out_payload_user),
        .out_payload_ready (out_payload_ready),
        .led               (led)
    );

    initial begin
        clk_125mhz = 1'b0;
        forever #4 clk_125mhz = ~clk_125mhz;
    end

    // Reply swaps ports, goes back to the sender, leaves from the local address
    function automatic hdr_t expected_reply(input hdr_t req);
        hdr_t rep;
        rep.src_ip   = DEFAULT_LOCAL_IP;
        rep.dst_ip   = req.src_ip;
        rep.src_port = req.dst_port;
        rep.dst_port = req.src_port;
        rep.length   = req.length;
        return rep;
    endfunction

    function automatic udp_port_t other_port();
        udp_port_t p;
        p = udp_port_t'($urandom);
        if (p == DEFAULT_ECHO_PORT) begin
            p = p + 16'd1;
        end
        return p;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_header();
        hdr_t exp;
        if (exp_hdr_q.size() == 0) begin
            $display("reply header appeared with no echoed request pending");
            errors++;
        end else begin
            exp = exp_hdr_q.pop_front();
            check_value("out_src_ip", out_src_ip, exp.src_ip);
            check_value("out_dst_ip", out_dst_ip, exp.dst_ip);
            check_value("out_src_port", 32'(out_src_port), 32'(exp.src_port));
            check_value("out_dst_port", 32'(out_dst_port), 32'(exp.dst_port));
            check_value("out_length", 32'(out_length), 32'(exp.length));
        end
    endtask

    task automatic compare_payload();
        beat_t exp;
        if (exp_pay_q.size() == 0) begin
            $display("reply payload byte appeared with no echoed byte pending");
            errors++;
        end else begin
            exp = exp_pay_q.pop_front();
            check_value("out_payload_data", 32'(out_payload_data), 32'(exp.data));
            check_value("out_payload_last", 32'(out_payload_last), 32'(exp.last));
            check_value("out_payload_user", 32'(out_payload_user), 32'(exp.user));
        end
    endtask

    // Values sampled at the edge where the transfer happens
    always @(posedge clk_125mhz) begin
        if (!rst_125mhz) begin
            if (out_hdr_valid && out_hdr_ready) begin
                compare_header();
            end
            if (out_payload_valid && out_payload_ready) begin
                compare_payload();
            end
        end
    end

    // Downstream back-pressure
    initial begin
        out_hdr_ready     = 1'b0;
        out_payload_ready = 1'b0;
        forever begin
            @(negedge clk_125mhz);
            out_hdr_ready     = stall_outputs ? (($urandom % 4) != 0) : 1'b1;
            out_payload_ready = stall_outputs ? (($urandom % 4) != 0) : 1'b1;
        end
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk_125mhz);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Test FAILED");
        $finish;
    end

    task automatic send_frame(input logic match);
        hdr_t  req;
        beat_t beat;
        int    n_bytes;
        int    i;
        req.src_ip   = $urandom;
        req.dst_ip   = $urandom;
        req.src_port = udp_port_t'($urandom);
        req.dst_port = match ? DEFAULT_ECHO_PORT : other_port();
        n_bytes      = int'($urandom_range(64, 1));
        req.length   = udp_len_t'(n_bytes + 8);
        if (req.dst_port == DEFAULT_ECHO_PORT) begin
            exp_hdr_q.push_back(expected_reply(req));
        end
        @(negedge clk_125mhz);
        in_hdr_valid = 1'b1;
        in_src_ip    = req.src_ip;
        in_dst_ip    = req.dst_ip;
        in_src_port  = req.src_port;
        in_dst_port  = req.dst_port;
        in_length    = req.length;
        @(posedge clk_125mhz);
        if (!match && !in_hdr_ready) begin
            $display("header to port 0x%h was not taken at once", req.dst_port);
            errors++;
        end
        while (!in_hdr_ready) @(posedge clk_125mhz);
        for (i = 0; i < n_bytes; i++) begin
            @(negedge clk_125mhz);
            in_hdr_valid = 1'b0;
            beat.last    = (i == n_bytes - 1);
            beat.user    = (($urandom % 8) == 0);
            beat.data    = byte_t'($urandom);
            if (match) begin
                exp_pay_q.push_back(beat);
                if (i == 0) begin
                    exp_led = beat.data;
                end
            end
            in_payload_valid = 1'b1;
            in_payload_last  = beat.last;
            in_payload_user  = beat.user;
            in_payload_data  = beat.data;
            @(posedge clk_125mhz);
            if (!match && !in_payload_ready) begin
                $display("payload byte of a dropped frame was not taken at once");
                errors++;
            end
            while (!in_payload_ready) @(posedge clk_125mhz);
        end
        @(negedge clk_125mhz);
        in_payload_valid = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_hdr_q.size() != 0 || exp_pay_q.size() != 0) @(negedge clk_125mhz);
        repeat (2) @(negedge clk_125mhz);
        if (out_hdr_valid || out_payload_valid) begin
            $display("output still valid after all expected replies left");
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("%s: %0d errors", name, errors - errors_before);
        tests_run++;
    endtask

    initial begin
        int mark;
        int n;
        void'($urandom(32'hf599_1088));
        errors           = 0;
        tests_run        = 0;
        exp_led          = '0;
        stall_outputs    = 1'b0;
        rst_125mhz       = 1'b1;
        in_hdr_valid     = 1'b0;
        in_src_ip        = '0;
        in_dst_ip        = '0;
        in_src_port      = '0;
        in_dst_port      = '0;
        in_length        = '0;
        in_payload_data  = '0;
        in_payload_valid = 1'b0;
        in_payload_last  = 1'b0;
        in_payload_user  = 1'b0;
        repeat (3) @(negedge clk_125mhz);
        rst_125mhz = 1'b0;

        mark = errors;
        check_value("out_hdr_valid", 32'(out_hdr_valid), 32'd0);
        check_value("out_payload_valid", 32'(out_payload_valid), 32'd0);
        check_value("led", 32'(led), 32'd0);
        report_test("reset state", mark);

        mark = errors;
        send_frame(1'b1);
        wait_drained();
        report_test("single echo frame", mark);

        // Four frames to other ports, then one echo
        mark = errors;
        for (n = 0; n < 4; n++) begin
            send_frame(1'b0);
        end
        send_frame(1'b1);
        wait_drained();
        report_test("other ports dropped", mark);

        mark = errors;
        stall_outputs = 1'b1;
        for (n = 0; n < 200; n++) begin
            send_frame(($urandom % 2) == 0);
        end
        wait_drained();
        stall_outputs = 1'b0;
        report_test("mixed frames with back-pressure", mark);

        mark = errors;
        check_value("led", 32'(led), 32'(exp_led));
        report_test("led shows first echoed byte", mark);

        $display("tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
hdl/udp_echo_pkg.sv
hdl/byte_stream_if.sv
hdl/udp_hdr_if.sv
hdl/udp_port_filter.sv
hdl/udp_reply_header.sv
hdl/payload_fifo.sv
hdl/led_capture.sv
hdl/udp_echo_top.sv
bench/tb_udp_echo.sv

// ==== run.sh ====
#!/bin/sh
# Compile the UDP echo testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f files.f --top-module tb_udp_echo -o tb_udp_echo \
    && ./obj_dir/tb_udp_echo | tee /dev/stderr | grep -q "Test OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
